/* mips_pkg.sv */
// shared widths, field codes and ALU encodings for the MIPS-32 subset core
// ALU op codes from the decoder follow the original control table encoding
package mips_pkg;

	// ------------------------------------------------------------------
	// widths with a meaning
	// ------------------------------------------------------------------
	// data, addresses and instructions
	typedef logic [31:0] word_t;
	// register index
	typedef logic [4:0] reg_addr_t;
	// instruction fields
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;
	// decoder to ALU control
	typedef logic [2:0] alu_op_t;

	// ALU function selected by ALU control
	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt
	} alu_fn_t;

	// ------------------------------------------------------------------
	// opcode and funct values
	// ------------------------------------------------------------------
	localparam opcode_t op_rtype = 6'b000000;
	localparam opcode_t op_addi  = 6'b001000;
	localparam opcode_t op_lw    = 6'b100011;
	localparam opcode_t op_sw    = 6'b101011;
	localparam opcode_t op_beq   = 6'b000100;

	localparam funct_t fn_add = 6'b100000;
	localparam funct_t fn_sub = 6'b100010;
	localparam funct_t fn_and = 6'b100100;
	localparam funct_t fn_or  = 6'b100101;
	localparam funct_t fn_slt = 6'b101010;

	// ALU op codes, decoder side
	localparam alu_op_t aluop_rtype = 3'b010;
	localparam alu_op_t aluop_add   = 3'b110;
	localparam alu_op_t aluop_sub   = 3'b001;

	// data memory, indexed by address bits 7 to 2
	localparam int dmem_words  = 64;
	localparam int dmem_addr_w = 6;

	// start address after reset
	localparam word_t reset_pc = 32'h0000_0000;

endpackage

/* instr_fetch.sv */
// pc holds reset_pc while reset is low and for one edge after release
// branch offset is expected already sign-extended, in words
`timescale 1ns/1ps

module instr_fetch (
	input  logic            clk_i,
	input  logic            arst_n_i,
	input  logic            branch_i,
	input  logic            zero_i,
	input  mips_pkg::word_t imm_i,
	output mips_pkg::word_t pc_o,
	output logic            run_o
);
	import mips_pkg::*;

	word_t pc_plus4;
	word_t br_target;
	word_t pc_next;
	logic  take_br;

	// ------------------------------------------------------------------
	// next pc
	// ------------------------------------------------------------------
	assign pc_plus4  = pc_o + 32'd4;
	// offset counts words, so shift by 2
	assign br_target = pc_plus4 + {imm_i[29:0], 2'b00};
	// beq taken only when operands compared equal
	assign take_br   = branch_i & zero_i;
	assign pc_next   = take_br ? br_target : pc_plus4;

	// ------------------------------------------------------------------
	// pc and run flag
	// ------------------------------------------------------------------
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_o  <= reset_pc;
			run_o <= 1'b0;
		end else begin
			// run goes high at first edge out of reset
			run_o <= 1'b1;
			// pc moves from the second edge on
			if (run_o) begin
				pc_o <= pc_next;
			end
		end
	end

endmodule

/* decoder.sv */
// main control table for R-type, addi, lw, sw and beq
// unknown opcodes decode to all-zero controls and act as a no-op
`timescale 1ns/1ps

module decoder (
	input  mips_pkg::opcode_t instr_op_i,
	input  logic              run_i,
	output logic              reg_dst_o,
	output logic              alu_src_o,
	output logic              reg_write_o,
	output logic              branch_o,
	output logic              mem_read_o,
	output logic              mem_write_o,
	output logic              mem_to_reg_o,
	output mips_pkg::alu_op_t alu_op_o
);
	import mips_pkg::*;

	// write enables before run gating
	logic reg_write;
	logic mem_write;

	always_comb begin
		// defaults give the no-op
		reg_dst_o    = 1'b0;
		alu_src_o    = 1'b0;
		reg_write    = 1'b0;
		branch_o     = 1'b0;
		mem_read_o   = 1'b0;
		mem_write    = 1'b0;
		mem_to_reg_o = 1'b0;
		alu_op_o     = '0;
		case (instr_op_i)
			op_rtype: begin
				// rd destination, funct picks the operation
				reg_dst_o = 1'b1;
				reg_write = 1'b1;
				alu_op_o  = aluop_rtype;
			end
			op_addi: begin
				// rt destination, immediate operand
				alu_src_o = 1'b1;
				reg_write = 1'b1;
				alu_op_o  = aluop_add;
			end
			op_lw: begin
				alu_src_o    = 1'b1;
				reg_write    = 1'b1;
				mem_read_o   = 1'b1;
				mem_to_reg_o = 1'b1;
				// base plus offset
				alu_op_o     = aluop_add;
			end
			op_sw: begin
				alu_src_o = 1'b1;
				mem_write = 1'b1;
				alu_op_o  = aluop_add;
			end
			op_beq: begin
				// rs minus rt, zero flag decides
				branch_o = 1'b1;
				alu_op_o = aluop_sub;
			end
			default: begin
				// illegal opcode, keep defaults
				alu_op_o = '0;
			end
		endcase
	end

	// ------------------------------------------------------------------
	// nothing is written until fetch starts running
	// ------------------------------------------------------------------
	assign reg_write_o = reg_write & run_i;
	assign mem_write_o = mem_write & run_i;

endmodule

/* alu_ctrl.sv */
// maps decoder ALU op and funct to one ALU function
// unknown funct under R-type falls back to add
`timescale 1ns/1ps

module alu_ctrl (
	input  mips_pkg::alu_op_t alu_op_i,
	input  mips_pkg::funct_t  funct_i,
	output mips_pkg::alu_fn_t alu_fn_o
);
	import mips_pkg::*;

	// funct decode for R-type
	alu_fn_t rtype_fn;

	always_comb begin
		case (funct_i)
			fn_add:  rtype_fn = alu_add;
			fn_sub:  rtype_fn = alu_sub;
			fn_and:  rtype_fn = alu_and;
			fn_or:   rtype_fn = alu_or;
			fn_slt:  rtype_fn = alu_slt;
			default: rtype_fn = alu_add;
		endcase
	end

	always_comb begin
		case (alu_op_i)
			// addi, lw and sw
			aluop_add:   alu_fn_o = alu_add;
			// beq compare
			aluop_sub:   alu_fn_o = alu_sub;
			aluop_rtype: alu_fn_o = rtype_fn;
			// no-op decode lands here
			default:     alu_fn_o = alu_add;
		endcase
	end

endmodule

/* reg_file.sv */
// 32 x 32-bit registers, reads are combinational, write at the rising edge
// register 0 reads zero, writes to it are dropped
`timescale 1ns/1ps

module reg_file (
	input  logic               clk_i,
	input  logic               arst_n_i,
	input  mips_pkg::reg_addr_t rs_addr_i,
	input  mips_pkg::reg_addr_t rt_addr_i,
	input  mips_pkg::reg_addr_t wr_addr_i,
	input  logic               wr_en_i,
	input  mips_pkg::word_t    wr_data_i,
	output mips_pkg::word_t    rs_data_o,
	output mips_pkg::word_t    rt_data_o
);
	import mips_pkg::*;

	word_t regs [32];

	// ------------------------------------------------------------------
	// write port
	// ------------------------------------------------------------------
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en_i && (wr_addr_i != '0)) begin
			regs[wr_addr_i] <= wr_data_i;
		end
	end

	// ------------------------------------------------------------------
	// read ports
	// ------------------------------------------------------------------
	// no bypass, single cycle reads old value
	assign rs_data_o = regs[rs_addr_i];
	assign rt_data_o = regs[rt_addr_i];

endmodule

/* alu.sv */
// 32-bit add, sub, and, or and signed set-less-than
// overflow is not detected
`timescale 1ns/1ps

module alu (
	input  mips_pkg::word_t   a_i,
	input  mips_pkg::word_t   b_i,
	input  mips_pkg::alu_fn_t fn_i,
	output mips_pkg::word_t   result_o,
	output logic              zero_o
);
	import mips_pkg::*;

	// signed compare result
	logic lt;

	assign lt = $signed(a_i) < $signed(b_i);

	always_comb begin
		case (fn_i)
			alu_add: begin
				result_o = a_i + b_i;
			end
			alu_sub: begin
				result_o = a_i - b_i;
			end
			alu_and: begin
				result_o = a_i & b_i;
			end
			alu_or: begin
				result_o = a_i | b_i;
			end
			alu_slt: begin
				// 1 in bit 0, rest clear
				result_o = {31'd0, lt};
			end
			default: begin
				result_o = a_i + b_i;
			end
		endcase
	end

	// beq uses this after a subtract
	assign zero_o = (result_o == '0);

endmodule

/* mem_writeback.sv */
// word data memory, index from address bits 7 to 2, upper bits ignored
// write-back picks the load word or the ALU result
`timescale 1ns/1ps

module mem_writeback (
	input  logic            clk_i,
	input  logic            arst_n_i,
	input  mips_pkg::word_t addr_i,
	input  mips_pkg::word_t wdata_i,
	input  logic            mem_write_i,
	input  logic            mem_to_reg_i,
	output mips_pkg::word_t wb_data_o
);
	import mips_pkg::*;

	word_t                  mem [dmem_words];
	logic [dmem_addr_w-1:0] idx;
	word_t                  rdata;

	// word index, byte offset dropped
	assign idx = addr_i[dmem_addr_w+1:2];

	// ------------------------------------------------------------------
	// store
	// ------------------------------------------------------------------
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < dmem_words; i++) begin
				mem[i] <= '0;
			end
		end else if (mem_write_i) begin
			mem[idx] <= wdata_i;
		end
	end

	// ------------------------------------------------------------------
	// load and write-back select
	// ------------------------------------------------------------------
	// combinational read, same cycle as address
	assign rdata = mem[idx];

	// addr_i doubles as the ALU result
	assign wb_data_o = mem_to_reg_i ? rdata : addr_i;

endmodule

/* cpu_top.sv */
// single-cycle core, one instruction per clock, no stalls
// instr_i must answer pc_o combinationally in the same cycle
`timescale 1ns/1ps

module cpu_top (
	input  logic                clk_i,
	input  logic                arst_n_i,
	input  mips_pkg::word_t     instr_i,
	output mips_pkg::word_t     pc_o,
	output logic                wb_en_o,
	output mips_pkg::reg_addr_t wb_addr_o,
	output mips_pkg::word_t     wb_data_o,
	output logic                dmem_we_o,
	output mips_pkg::word_t     dmem_addr_o,
	output mips_pkg::word_t     dmem_wdata_o
);
	import mips_pkg::*;

	// fetch
	logic      run;
	// decoder controls
	logic      reg_dst;
	logic      alu_src;
	logic      reg_write;
	logic      branch;
	logic      mem_write;
	logic      mem_to_reg;
	alu_op_t   alu_op;
	alu_fn_t   alu_fn;
	// datapath
	word_t     rs_data;
	word_t     rt_data;
	word_t     alu_result;
	logic      alu_zero;
	word_t     wb_data;
	word_t     imm_ext;
	reg_addr_t wr_addr;

	// ------------------------------------------------------------------
	// instruction field wiring
	// ------------------------------------------------------------------
	// sign-extended 16-bit immediate
	assign imm_ext = {{16{instr_i[15]}}, instr_i[15:0]};
	// rd for R-type, rt otherwise
	assign wr_addr = reg_dst ? instr_i[15:11] : instr_i[20:16];

	// ------------------------------------------------------------------
	// input side
	// ------------------------------------------------------------------
	instr_fetch u_fetch (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.branch_i (branch),
		.zero_i   (alu_zero),
		.imm_i    (imm_ext),
		.pc_o     (pc_o),
		.run_o    (run)
	);

	// ------------------------------------------------------------------
	// processing part
	// ------------------------------------------------------------------
	// mem_read is left open, the load path reads every cycle
	decoder u_dec (
		.instr_op_i   (instr_i[31:26]),
		.run_i        (run),
		.reg_dst_o    (reg_dst),
		.alu_src_o    (alu_src),
		.reg_write_o  (reg_write),
		.branch_o     (branch),
		.mem_read_o   (),
		.mem_write_o  (mem_write),
		.mem_to_reg_o (mem_to_reg),
		.alu_op_o     (alu_op)
	);

	alu_ctrl u_alu_ctrl (
		.alu_op_i (alu_op),
		.funct_i  (instr_i[5:0]),
		.alu_fn_o (alu_fn)
	);

	reg_file u_regs (
		.clk_i     (clk_i),
		.arst_n_i  (arst_n_i),
		.rs_addr_i (instr_i[25:21]),
		.rt_addr_i (instr_i[20:16]),
		.wr_addr_i (wr_addr),
		.wr_en_i   (reg_write),
		.wr_data_i (wb_data),
		.rs_data_o (rs_data),
		.rt_data_o (rt_data)
	);

	// second operand is immediate for addi, lw, sw
	alu u_alu (
		.a_i      (rs_data),
		.b_i      (alu_src ? imm_ext : rt_data),
		.fn_i     (alu_fn),
		.result_o (alu_result),
		.zero_o   (alu_zero)
	);

	// ------------------------------------------------------------------
	// output side
	// ------------------------------------------------------------------
	mem_writeback u_mem_wb (
		.clk_i        (clk_i),
		.arst_n_i     (arst_n_i),
		.addr_i       (alu_result),
		.wdata_i      (rt_data),
		.mem_write_i  (mem_write),
		.mem_to_reg_i (mem_to_reg),
		.wb_data_o    (wb_data)
	);

	// observation ports, all take effect at the next edge
	assign wb_en_o      = reg_write;
	assign wb_addr_o    = wr_addr;
	assign wb_data_o    = wb_data;
	assign dmem_we_o    = mem_write;
	assign dmem_addr_o  = alu_result;
	assign dmem_wdata_o = rt_data;

endmodule

/* tb_checker.sv */
// reference model of the MIPS subset sampled at every rising clock edge
// expects instr_i stable from the falling edge and a 64-word data memory
`timescale 1ns/1ps

module tb_checker (
	input  logic                clk_i,
	input  logic                arst_n_i,
	input  mips_pkg::word_t     pc_i,
	input  mips_pkg::word_t     instr_i,
	input  logic                wb_en_i,
	input  mips_pkg::reg_addr_t wb_addr_i,
	input  mips_pkg::word_t     wb_data_i,
	input  logic                dmem_we_i,
	input  mips_pkg::word_t     dmem_addr_i,
	input  mips_pkg::word_t     dmem_wdata_i,
	output logic                started_o,
	output int                  retired_o,
	output int                  checks_o,
	output int                  errors_o
);
	import mips_pkg::*;

	// model state
	word_t m_regs [32];
	word_t m_mem [64];
	word_t m_pc;
	// test that owns the next pc compare
	int    pc_test;
	// per-test bookkeeping
	int    checks [1:6];
	int    errs [1:6];
	int    chk_total;
	int    err_total;
	string test_name [1:6];

	assign checks_o = chk_total;
	assign errors_o = err_total;

	initial begin
		test_name[1] = "reset state and pc step";
		test_name[2] = "arithmetic write-back";
		test_name[3] = "store";
		test_name[4] = "load";
		test_name[5] = "branch";
		test_name[6] = "illegal opcode";
		for (int i = 1; i <= 6; i++) begin
			checks[i] = 0;
			errs[i]   = 0;
		end
		chk_total = 0;
		err_total = 0;
	end

	// ------------------------------------------------------------------
	// compare helpers
	// ------------------------------------------------------------------
	task automatic compare(input int test_id, input word_t got, input word_t exp,
			input string what);
		checks[test_id]++;
		chk_total++;
		if (got !== exp) begin
			errs[test_id]++;
			err_total++;
			$display("error at %0t ns: test %0d %s, pc %h instr %h, expected %h, got %h",
				$time, test_id, what, pc_i, instr_i, exp, got);
		end
	endtask

	// neither a register write nor a store
	task automatic expect_quiet(input int test_id);
		compare(test_id, wb_en_i, 0, "wb_en");
		compare(test_id, dmem_we_i, 0, "dmem_we");
	endtask

	// register write of value to dst and model update that keeps r0 at zero
	task automatic expect_write(input int test_id, input reg_addr_t dst, input word_t value);
		compare(test_id, wb_en_i, 1, "wb_en");
		compare(test_id, wb_addr_i, dst, "wb_addr");
		compare(test_id, wb_data_i, value, "wb_data");
		compare(test_id, dmem_we_i, 0, "dmem_we");
		if (dst != 0) begin
			m_regs[dst] = value;
		end
	endtask

	// ------------------------------------------------------------------
	// one instruction of the model
	// ------------------------------------------------------------------
	task automatic step_model();
		reg_addr_t rs;
		reg_addr_t rt;
		word_t     imm;
		word_t     a;
		word_t     b;
		word_t     res;
		word_t     addr;
		word_t     next_pc;
		rs   = instr_i[25:21];
		rt   = instr_i[20:16];
		imm  = {{16{instr_i[15]}}, instr_i[15:0]};
		a    = m_regs[rs];
		b    = m_regs[rt];
		addr = a + imm;
		// pc that the previous instruction produced
		compare(pc_test, pc_i, m_pc, "pc");
		next_pc = m_pc + 32'd4;
		pc_test = 1;
		case (instr_i[31:26])
			op_rtype: begin
				case (instr_i[5:0])
					fn_sub:  res = a - b;
					fn_and:  res = a & b;
					fn_or:   res = a | b;
					fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: res = a + b;
				endcase
				expect_write(2, instr_i[15:11], res);
			end
			op_addi: begin
				expect_write(2, rt, a + imm);
			end
			op_lw: begin
				expect_write(4, rt, m_mem[addr[7:2]]);
			end
			op_sw: begin
				compare(3, dmem_we_i, 1, "dmem_we");
				compare(3, wb_en_i, 0, "wb_en");
				compare(3, dmem_addr_i, addr, "dmem_addr");
				compare(3, dmem_wdata_i, b, "dmem_wdata");
				m_mem[addr[7:2]] = b;
			end
			op_beq: begin
				expect_quiet(5);
				// offset counts words from pc plus 4
				if (a == b) begin
					next_pc = m_pc + 32'd4 + (imm << 2);
				end
				pc_test = 5;
			end
			default: begin
				expect_quiet(6);
				pc_test = 6;
			end
		endcase
		m_pc = next_pc;
	endtask

	always @(posedge clk_i) begin
		if (!arst_n_i) begin
			// core state is defined once reset has been held over an edge
			if (started_o === 1'b0) begin
				compare(1, pc_i, reset_pc, "pc in reset");
				expect_quiet(1);
			end
			for (int i = 0; i < 32; i++) begin
				m_regs[i] = '0;
			end
			for (int i = 0; i < 64; i++) begin
				m_mem[i] = '0;
			end
			m_pc      = reset_pc;
			pc_test   = 1;
			started_o <= 1'b0;
			retired_o <= 0;
		end else if (started_o !== 1'b1) begin
			// first edge out of reset while the core is not running yet
			compare(1, pc_i, reset_pc, "pc on first edge");
			expect_quiet(1);
			started_o <= 1'b1;
		end else begin
			step_model();
			retired_o <= retired_o + 1;
		end
	end

	// ------------------------------------------------------------------
	// summary
	// ------------------------------------------------------------------
	task automatic print_summary();
		string status;
		for (int i = 1; i <= 6; i++) begin
			if (errs[i] != 0) begin
				status = "mismatch";
			end else if (checks[i] == 0) begin
				status = "not exercised";
			end else begin
				status = "ok";
			end
			$display("test %0d %s: %0d checks, %0d errors, %s", i, test_name[i],
				checks[i], errs[i], status);
		end
		$display("totals: %0d checks, %0d errors, %0d instructions retired",
			chk_total, err_total, retired_o);
	endtask

endmodule

/* tb_cpu.sv */
// random program over r0 to r7 in a 64-word instruction memory, indexed by pc bits 7 to 2
// beq offsets skip -1 so an equal compare cannot spin on one instruction
`timescale 1ns/1ps

module tb_cpu;
	import mips_pkg::*;

	logic      clk;
	logic      arst_n;
	word_t     instr;
	word_t     pc;
	logic      wb_en;
	reg_addr_t wb_addr;
	word_t     wb_data;
	logic      dmem_we;
	word_t     dmem_addr;
	word_t     dmem_wdata;
	// checker status
	logic      started;
	int        retired;
	int        checks;
	int        errors;
	integer    seed;
	int        cnt;
	word_t     imem [64];

	always #5 clk = ~clk;

	// ------------------------------------------------------------------
	// program generation
	// ------------------------------------------------------------------
	task automatic fill_imem();
		int          pick;
		int          k;
		reg_addr_t   rs;
		reg_addr_t   rt;
		reg_addr_t   rd;
		logic [15:0] imm;
		word_t       raw;
		funct_t      fn_list [5];
		fn_list[0] = fn_add;
		fn_list[1] = fn_sub;
		fn_list[2] = fn_and;
		fn_list[3] = fn_or;
		fn_list[4] = fn_slt;
		for (int i = 0; i < 64; i++) begin
			pick = {$random(seed)} % 20;
			rs   = {$random(seed)} % 8;
			rt   = {$random(seed)} % 8;
			rd   = {$random(seed)} % 8;
			imm  = $random(seed);
			raw  = $random(seed);
			k    = {$random(seed)} % 64;
			if (pick == 0) begin
				// opcodes 11xxxx are all outside the subset
				imem[i] = {2'b11, raw[29:0]};
			end else if (pick < 7) begin
				imem[i] = {op_rtype, rs, rt, rd, 5'd0, fn_list[k % 5]};
			end else if (pick < 11) begin
				imem[i] = {op_addi, rs, rt, imm};
			end else if (pick < 14) begin
				// base r0, aligned offset below 256
				imm     = k * 4;
				imem[i] = {op_lw, 5'd0, rt, imm};
			end else if (pick < 17) begin
				imm     = k * 4;
				imem[i] = {op_sw, 5'd0, rt, imm};
			end else begin
				// -4, -3, -2, then 0 to 4
				k       = k % 8;
				imm     = (k < 3) ? (k - 4) : (k - 3);
				imem[i] = {op_beq, rs, rt, imm};
			end
		end
	endtask

	// fetch port answered on the falling edge
	always @(negedge clk) begin
		instr <= imem[pc[7:2]];
	end

	cpu_top dut0 (
		.clk_i        (clk),
		.arst_n_i     (arst_n),
		.instr_i      (instr),
		.pc_o         (pc),
		.wb_en_o      (wb_en),
		.wb_addr_o    (wb_addr),
		.wb_data_o    (wb_data),
		.dmem_we_o    (dmem_we),
		.dmem_addr_o  (dmem_addr),
		.dmem_wdata_o (dmem_wdata)
	);

	tb_checker chk0 (
		.clk_i        (clk),
		.arst_n_i     (arst_n),
		.pc_i         (pc),
		.instr_i      (instr),
		.wb_en_i      (wb_en),
		.wb_addr_i    (wb_addr),
		.wb_data_i    (wb_data),
		.dmem_we_i    (dmem_we),
		.dmem_addr_i  (dmem_addr),
		.dmem_wdata_i (dmem_wdata),
		.started_o    (started),
		.retired_o    (retired),
		.checks_o     (checks),
		.errors_o     (errors)
	);

	initial begin
		seed   = 32'h1939;
		clk    = 1'b0;
		arst_n = 1'b0;
		instr  = '0;
		fill_imem();
		repeat (5) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		// checker sees the first edge out of reset
		cnt = 0;
		while (started !== 1'b1 && cnt < 10) begin
			@(posedge clk);
			cnt++;
		end
		if (started !== 1'b1) begin
			$display("timeout: core did not leave reset within 10 cycles");
			$display("Some tests failed");
			$finish;
		end
		// 2000 instructions, one per clock
		cnt = 0;
		while (retired < 2000 && cnt < 2100) begin
			@(posedge clk);
			cnt++;
		end
		if (retired < 2000) begin
			$display("timeout: only %0d of 2000 instructions retired", retired);
			$display("Some tests failed");
			$finish;
		end
		@(negedge clk);
		chk0.print_summary();
		if (errors == 0 && checks > 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* compile.f */
mips_pkg.sv
instr_fetch.sv
decoder.sv
alu_ctrl.sv
reg_file.sv
alu.sv
mem_writeback.sv
cpu_top.sv
tb_checker.sv
tb_cpu.sv
